/* design/rca_config_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module rca_config_regs #(
    parameter int XLEN = 32
) (
    input  wire                                                          clk,
    input  wire                                                          rst_n,
    input  wire                                                          issue_valid,
    input  wire rca_pkg::rca_op_t                                        issue_op,
    input  wire  [rca_pkg::CFG_ADDR_WIDTH-1:0]                           cfg_addr,
    input  wire  [XLEN-1:0]                                              cfg_data,
    input  wire                                                          config_locked,
    output logic [rca_pkg::NUM_IO_UNITS*rca_pkg::IO_SEL_WIDTH-1:0]       io_sels,
    output logic [rca_pkg::NUM_IO_UNITS*XLEN-1:0]                        constants,
    output logic [rca_pkg::NUM_WRITE_PORTS*rca_pkg::RESULT_SEL_WIDTH-1:0] result_sels
);

    import rca_pkg::*;

    logic cfg_wr_en;
    logic io_sel_wr;
    logic constant_wr;
    logic result_sel_wr;
    logic port_addr_ok;

    // lock comes from the grid control, no second check here
    assign cfg_wr_en = issue_valid && !config_locked;

    assign io_sel_wr     = cfg_wr_en && (issue_op == op_cfg_io_sel);
    assign constant_wr   = cfg_wr_en && (issue_op == op_cfg_constant);
    assign result_sel_wr = cfg_wr_en && (issue_op == op_cfg_result_sel);

    // only two write ports behind a 2-bit address
    assign port_addr_ok = (int'(cfg_addr) < NUM_WRITE_PORTS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            io_sels <= '0; // every unit reads rs1
        end else if (io_sel_wr) begin
            io_sels[cfg_addr*IO_SEL_WIDTH +: IO_SEL_WIDTH] <= cfg_data[IO_SEL_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            constants <= '0;
        end else if (constant_wr) begin
            constants[cfg_addr*XLEN +: XLEN] <= cfg_data;
        end
    end

    // results read zero until configured
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < NUM_WRITE_PORTS; p++) begin
                result_sels[p*RESULT_SEL_WIDTH +: RESULT_SEL_WIDTH] <= RESULT_SEL_ZERO;
            end
        end else if (result_sel_wr && port_addr_ok) begin
            result_sels[cfg_addr*RESULT_SEL_WIDTH +: RESULT_SEL_WIDTH] <=
                cfg_data[RESULT_SEL_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

/* design/rca_grid.sv */
`timescale 1ns/100ps
`default_nettype none

module rca_grid #(
    parameter int XLEN = 32
) (
    input  wire                                                    clk,
    input  wire                                                    rst_n,
    input  wire                                                    issue_valid,
    input  wire rca_pkg::rca_op_t                                  issue_op,
    input  wire  [XLEN-1:0]                                        rs1,
    input  wire  [XLEN-1:0]                                        rs2,
    input  wire  [rca_pkg::NUM_IO_UNITS*rca_pkg::IO_SEL_WIDTH-1:0] io_sels,
    input  wire  [rca_pkg::NUM_IO_UNITS*XLEN-1:0]                  constants,
    output logic [rca_pkg::NUM_IO_UNITS*XLEN-1:0]                  unit_data
);

    import rca_pkg::*;

    logic                    use_issue;
    logic                    s1_valid;
    logic [IO_SEL_WIDTH-1:0] unit_sel [NUM_IO_UNITS];
    logic [XLEN-1:0]         unit_const [NUM_IO_UNITS];

    // stage 1 operands and results
    logic [XLEN-1:0] u0_a;
    logic [XLEN-1:0] u1_a;
    logic [XLEN-1:0] u0_out;
    logic [XLEN-1:0] u1_out;

    // stage 1 registers
    logic [XLEN-1:0] s1_rs1;
    logic [XLEN-1:0] s1_rs2;
    logic [XLEN-1:0] s1_u0;
    logic [XLEN-1:0] s1_u1;

    // stage 2 operands and results
    logic [XLEN-1:0] u2_a;
    logic [XLEN-1:0] u3_a;
    logic [XLEN-1:0] u2_out;
    logic [XLEN-1:0] u3_out;

    function automatic logic [XLEN-1:0] pick_operand(
        input logic [IO_SEL_WIDTH-1:0] sel,
        input logic [XLEN-1:0]         src_rs1,
        input logic [XLEN-1:0]         src_rs2,
        input logic [XLEN-1:0]         prev
    );
        case (sel)
            IO_SEL_RS1:  return src_rs1;
            IO_SEL_RS2:  return src_rs2;
            IO_SEL_PREV: return prev;
            IO_SEL_ZERO: return '0;
            default:     return '0;
        endcase
    endfunction

    assign use_issue = issue_valid && (issue_op == op_use);

    always_comb begin
        for (int u = 0; u < NUM_IO_UNITS; u++) begin
            unit_sel[u]   = io_sels[u*IO_SEL_WIDTH +: IO_SEL_WIDTH];
            unit_const[u] = constants[u*XLEN +: XLEN];
        end
    end

    always_comb begin
        u0_a   = pick_operand(unit_sel[0], rs1, rs2, '0); // no unit before 0
        u0_out = u0_a + unit_const[0];
        u1_a   = pick_operand(unit_sel[1], rs1, rs2, u0_out);
        u1_out = u1_a ^ unit_const[1];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= use_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (use_issue) begin
            s1_rs1 <= rs1;
            s1_rs2 <= rs2;
            s1_u0  <= u0_out;
            s1_u1  <= u1_out;
        end
    end

    // stage 2 chains off the registered unit 1 result
    always_comb begin
        u2_a   = pick_operand(unit_sel[2], s1_rs1, s1_rs2, s1_u1);
        u2_out = u2_a - unit_const[2];
        u3_a   = pick_operand(unit_sel[3], s1_rs1, s1_rs2, u2_out);
        u3_out = u3_a << unit_const[3][SHAMT_WIDTH-1:0];
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            unit_data <= {u3_out, u2_out, s1_u1, s1_u0};
        end
    end

endmodule

`default_nettype wire

/* design/rca_grid_control.sv */
`timescale 1ns/100ps
`default_nettype none

module rca_grid_control #(
    parameter int ID_WIDTH = 4
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   issue_valid,
    input  wire rca_pkg::rca_op_t issue_op,
    input  wire  [ID_WIDTH-1:0]   issue_id,
    output logic                  use_done,
    output logic [ID_WIDTH-1:0]   use_id,
    output logic                  cfg_done,
    output logic [ID_WIDTH-1:0]   cfg_id,
    output logic                  config_locked
);

    import rca_pkg::*;

    logic                use_issue;
    logic                cfg_issue;
    logic [USE_LATENCY-1:0] use_valid; // one bit per grid stage
    logic [ID_WIDTH-1:0] use_ids [USE_LATENCY];

    assign use_issue = issue_valid && (issue_op == op_use);
    assign cfg_issue = issue_valid && (issue_op != op_use) && !config_locked;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            use_valid <= '0;
            cfg_done  <= 1'b0;
        end else begin
            use_valid <= {use_valid[USE_LATENCY-2:0], use_issue};
            cfg_done  <= cfg_issue;
        end
    end

    always_ff @(posedge clk) begin
        use_ids[0] <= issue_id;
        for (int s = 1; s < USE_LATENCY; s++) begin
            use_ids[s] <= use_ids[s-1];
        end
        if (cfg_issue) begin
            cfg_id <= issue_id;
        end
    end

    assign use_done = use_valid[USE_LATENCY-1];
    assign use_id   = use_ids[USE_LATENCY-1];

    // held until the last use in flight shows done
    assign config_locked = |use_valid;

endmodule

`default_nettype wire

/* design/rca_pkg.sv */
`default_nettype none

package rca_pkg;

    // instruction kinds seen at the issue port
    typedef enum logic [1:0] {
        op_cfg_io_sel     = 2'd0,
        op_cfg_constant   = 2'd1,
        op_cfg_result_sel = 2'd2,
        op_use            = 2'd3
    } rca_op_t;

    localparam int NUM_IO_UNITS    = 4;
    localparam int NUM_WRITE_PORTS = 2;

    // io unit source select codes
    localparam int IO_SEL_WIDTH = 2;

    localparam logic [IO_SEL_WIDTH-1:0] IO_SEL_RS1  = 2'd0;
    localparam logic [IO_SEL_WIDTH-1:0] IO_SEL_RS2  = 2'd1;
    localparam logic [IO_SEL_WIDTH-1:0] IO_SEL_PREV = 2'd2; // previous unit, zero for unit 0
    localparam logic [IO_SEL_WIDTH-1:0] IO_SEL_ZERO = 2'd3;

    // result select: 0..3 name a unit, 4..7 read zero
    localparam int RESULT_SEL_WIDTH = 3;

    localparam logic [RESULT_SEL_WIDTH-1:0] RESULT_SEL_ZERO = 3'd4;

    // unit index, or write port index for result selects
    localparam int CFG_ADDR_WIDTH = 2;

    // shift amount taken from the low constant bits of unit 3
    localparam int SHAMT_WIDTH = 5;

    // pipeline depth of a use instruction
    localparam int USE_LATENCY = 2;

endpackage

`default_nettype wire

/* design/rca_result_wb.sv */
`timescale 1ns/100ps
`default_nettype none

module rca_result_wb #(
    parameter int XLEN     = 32,
    parameter int ID_WIDTH = 4
) (
    input  wire                                                          clk,
    input  wire                                                          rst_n,
    input  wire  [rca_pkg::NUM_IO_UNITS*XLEN-1:0]                        unit_data,
    input  wire  [rca_pkg::NUM_WRITE_PORTS*rca_pkg::RESULT_SEL_WIDTH-1:0] result_sels,
    input  wire                                                          use_done,
    input  wire  [ID_WIDTH-1:0]                                          use_id,
    input  wire                                                          cfg_done,
    input  wire  [ID_WIDTH-1:0]                                          cfg_id,
    output logic                                                         wb_done,
    output logic [ID_WIDTH-1:0]                                          wb_id,
    output logic [XLEN-1:0]                                              wb_rd0,
    output logic [XLEN-1:0]                                              wb_rd1
);

    import rca_pkg::*;

    logic [RESULT_SEL_WIDTH-1:0] port_sel [NUM_WRITE_PORTS];
    logic [XLEN-1:0]             port_data [NUM_WRITE_PORTS];
    logic [ID_WIDTH-1:0]         last_id;

    // codes past the last unit fall through to zero
    always_comb begin
        for (int p = 0; p < NUM_WRITE_PORTS; p++) begin
            port_sel[p]  = result_sels[p*RESULT_SEL_WIDTH +: RESULT_SEL_WIDTH];
            port_data[p] = '0;
            for (int u = 0; u < NUM_IO_UNITS; u++) begin
                if (port_sel[p] == RESULT_SEL_WIDTH'(u)) begin
                    port_data[p] = unit_data[u*XLEN +: XLEN];
                end
            end
        end
    end

    assign wb_done = use_done || cfg_done;

    // config completions carry zero data
    assign wb_rd0 = use_done ? port_data[0] : '0;
    assign wb_rd1 = use_done ? port_data[1] : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_id <= '0;
        end else if (wb_done) begin
            last_id <= wb_id;
        end
    end

    always_comb begin
        if (use_done) begin
            wb_id = use_id;
        end else if (cfg_done) begin
            wb_id = cfg_id;
        end else begin
            wb_id = last_id; // hold between completions
        end
    end

endmodule

`default_nettype wire

/* design/rca_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module rca_unit #(
    parameter int XLEN     = 32,
    parameter int ID_WIDTH = 4
) (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                issue_valid,
    input  wire rca_pkg::rca_op_t              issue_op,
    input  wire  [ID_WIDTH-1:0]                issue_id,
    input  wire  [rca_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  wire  [XLEN-1:0]                    cfg_data,
    input  wire  [XLEN-1:0]                    rs1,
    input  wire  [XLEN-1:0]                    rs2,
    output logic                               wb_done,
    output logic [ID_WIDTH-1:0]                wb_id,
    output logic [XLEN-1:0]                    wb_rd0,
    output logic [XLEN-1:0]                    wb_rd1,
    output logic                               config_locked
);

    import rca_pkg::*;

    logic [NUM_IO_UNITS*IO_SEL_WIDTH-1:0]        io_sels;
    logic [NUM_IO_UNITS*XLEN-1:0]                constants;
    logic [NUM_WRITE_PORTS*RESULT_SEL_WIDTH-1:0] result_sels;
    logic [NUM_IO_UNITS*XLEN-1:0]                unit_data;

    logic                use_done;
    logic [ID_WIDTH-1:0] use_id;
    logic                cfg_done;
    logic [ID_WIDTH-1:0] cfg_id;

    rca_config_regs #(
        .XLEN(XLEN)
    ) i_config_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .config_locked(config_locked),
        .io_sels      (io_sels),
        .constants    (constants),
        .result_sels  (result_sels)
    );

    rca_grid #(
        .XLEN(XLEN)
    ) i_grid (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue_valid(issue_valid),
        .issue_op   (issue_op),
        .rs1        (rs1),
        .rs2        (rs2),
        .io_sels    (io_sels),
        .constants  (constants),
        .unit_data  (unit_data)
    );

    // runs beside the grid, same two-stage depth
    rca_grid_control #(
        .ID_WIDTH(ID_WIDTH)
    ) i_grid_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_id     (issue_id),
        .use_done     (use_done),
        .use_id       (use_id),
        .cfg_done     (cfg_done),
        .cfg_id       (cfg_id),
        .config_locked(config_locked)
    );

    rca_result_wb #(
        .XLEN    (XLEN),
        .ID_WIDTH(ID_WIDTH)
    ) i_result_wb (
        .clk        (clk),
        .rst_n      (rst_n),
        .unit_data  (unit_data),
        .result_sels(result_sels),
        .use_done   (use_done),
        .use_id     (use_id),
        .cfg_done   (cfg_done),
        .cfg_id     (cfg_id),
        .wb_done    (wb_done),
        .wb_id      (wb_id),
        .wb_rd0     (wb_rd0),
        .wb_rd1     (wb_rd1)
    );

endmodule

`default_nettype wire

/* project.f */
+incdir+testbench
design/rca_pkg.sv
design/rca_config_regs.sv
design/rca_grid.sv
design/rca_grid_control.sv
design/rca_result_wb.sv
design/rca_unit.sv
testbench/tb_rca_unit.sv

/* testbench/tb_rca_table.svh */
`ifndef TB_RCA_TABLE_SVH
`define TB_RCA_TABLE_SVH

// one issue strobe per entry, with its expected completion
typedef struct packed {
    logic [3:0]                gap;      // idle cycles before the strobe
    rca_op_t                   op;
    logic [ID_WIDTH-1:0]       id;
    logic [CFG_ADDR_WIDTH-1:0] addr;
    logic [XLEN-1:0]           data;
    logic [XLEN-1:0]           rs1;
    logic [XLEN-1:0]           rs2;
    logic                      done_exp; // low for a config dropped by the lock
    logic [XLEN-1:0]           rd0;
    logic [XLEN-1:0]           rd1;
} stim_entry_t;

stim_entry_t stim_q [$];

task automatic add_entry(
    input int              gap,
    input rca_op_t         op,
    input int              id,
    input int              addr,
    input logic [XLEN-1:0] data,
    input logic [XLEN-1:0] a_rs1,
    input logic [XLEN-1:0] a_rs2,
    input bit              done_exp,
    input logic [XLEN-1:0] rd0,
    input logic [XLEN-1:0] rd1
);
    stim_entry_t e;
    e.gap      = 4'(gap);
    e.op       = op;
    e.id       = ID_WIDTH'(id);
    e.addr     = CFG_ADDR_WIDTH'(addr);
    e.data     = data;
    e.rs1      = a_rs1;
    e.rs2      = a_rs2;
    e.done_exp = done_exp;
    e.rd0      = rd0;
    e.rd1      = rd1;
    stim_q.push_back(e);
endtask

// columns: gap, op, id, addr, data, rs1, rs2, done expected, rd0, rd1
task automatic build_table();
    // result selects still 4 after reset
    add_entry(2, op_use, 1, 0, 32'h0, 32'h1234, 32'h5678, 1, 32'h0, 32'h0);
    // unit 0 add, unit 1 xor, both on rs1
    add_entry(2, op_cfg_constant, 2, 0, 32'h10, 32'h0, 32'h0, 1, 32'h0, 32'h0);
    add_entry(0, op_cfg_result_sel, 3, 0, 32'h0, 32'h0, 32'h0, 1, 32'h0, 32'h0);
    add_entry(0, op_cfg_result_sel, 4, 1, 32'h1, 32'h0, 32'h0, 1, 32'h0, 32'h0);
    add_entry(0, op_cfg_constant, 5, 1, 32'hff00ff00, 32'h0, 32'h0, 1, 32'h0, 32'h0);
    add_entry(1, op_use, 6, 0, 32'h0, 32'h100, 32'hf, 1, 32'h110, 32'hff00fe00);
    // unit 1 chained on unit 0, unit 2 subtracts from rs2
    add_entry(2, op_cfg_io_sel, 7, 1, 32'h2, 32'h0, 32'h0, 1, 32'h0, 32'h0);
    add_entry(0, op_cfg_io_sel, 8, 2, 32'h1, 32'h0, 32'h0, 1, 32'h0, 32'h0);
    add_entry(0, op_cfg_constant, 9, 2, 32'h5, 32'h0, 32'h0, 1, 32'h0, 32'h0);
    add_entry(0, op_cfg_result_sel, 10, 0, 32'h2, 32'h0, 32'h0, 1, 32'h0, 32'h0);
    add_entry(0, op_use, 11, 0, 32'h0, 32'h20, 32'h3, 1, 32'hfffffffe, 32'hff00ff30);
    // full chain 0 -> 1 -> 2 -> 3, shift by 0x24 & 31 = 4
    add_entry(2, op_cfg_io_sel, 12, 3, 32'h2, 32'h0, 32'h0, 1, 32'h0, 32'h0);
    add_entry(0, op_cfg_constant, 13, 3, 32'h24, 32'h0, 32'h0, 1, 32'h0, 32'h0);
    add_entry(0, op_cfg_result_sel, 14, 1, 32'h3, 32'h0, 32'h0, 1, 32'h0, 32'h0);
    add_entry(0, op_cfg_io_sel, 15, 2, 32'h2, 32'h0, 32'h0, 1, 32'h0, 32'h0);
    add_entry(0, op_use, 0, 0, 32'h0, 32'h1, 32'h0, 1, 32'hff00ff0c, 32'hf00ff0c0);
    // back to back uses
    add_entry(1, op_use, 1, 0, 32'h0, 32'h100, 32'h7, 1, 32'hff00fe0b, 32'hf00fe0b0);
    add_entry(0, op_use, 2, 0, 32'h0, 32'hfffffff0, 32'h0, 1, 32'hff00fefb, 32'hf00fefb0);
    add_entry(0, op_use, 3, 0, 32'h0, 32'h0, 32'h0, 1, 32'hff00ff0b, 32'hf00ff0b0);
    // configs one and two cycles after a use are dropped
    add_entry(2, op_use, 4, 0, 32'h0, 32'h2, 32'h0, 1, 32'hff00ff0d, 32'hf00ff0d0);
    add_entry(0, op_cfg_result_sel, 5, 0, 32'h0, 32'h0, 32'h0, 0, 32'h0, 32'h0);
    add_entry(0, op_cfg_constant, 6, 2, 32'h100, 32'h0, 32'h0, 0, 32'h0, 32'h0);
    add_entry(1, op_use, 7, 0, 32'h0, 32'h3, 32'h0, 1, 32'hff00ff0e, 32'hf00ff0e0);
    // select code 7 reads zero
    add_entry(2, op_cfg_result_sel, 8, 0, 32'h7, 32'h0, 32'h0, 1, 32'h0, 32'h0);
    add_entry(0, op_use, 9, 0, 32'h0, 32'h3, 32'h0, 1, 32'h0, 32'hf00ff0e0);
endtask

`endif

/* testbench/tb_rca_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rca_unit;

    import rca_pkg::*;

    localparam int XLEN     = 32;
    localparam int ID_WIDTH = 4;

    logic                      clk;
    logic                      rst_n;
    logic                      issue_valid;
    rca_op_t                   issue_op;
    logic [ID_WIDTH-1:0]       issue_id;
    logic [CFG_ADDR_WIDTH-1:0] cfg_addr;
    logic [XLEN-1:0]           cfg_data;
    logic [XLEN-1:0]           rs1;
    logic [XLEN-1:0]           rs2;
    logic                      wb_done;
    logic [ID_WIDTH-1:0]       wb_id;
    logic [XLEN-1:0]           wb_rd0;
    logic [XLEN-1:0]           wb_rd1;
    logic                      config_locked;

    `include "tb_rca_table.svh"

    // completion waiting to be seen on the writeback port
    typedef struct packed {
        logic [31:0]         due;
        logic                is_use;
        logic [ID_WIDTH-1:0] id;
        logic [XLEN-1:0]     rd0;
        logic [XLEN-1:0]     rd1;
    } done_exp_t;

    done_exp_t           exp_q [$];
    int                  cyc;
    int                  err_cnt;
    logic                mon_en;
    logic [ID_WIDTH-1:0] held_id;

    rca_unit #(
        .XLEN    (XLEN),
        .ID_WIDTH(ID_WIDTH)
    ) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_id     (issue_id),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .rs1          (rs1),
        .rs2          (rs2),
        .wb_done      (wb_done),
        .wb_id        (wb_id),
        .wb_rd0       (wb_rd0),
        .wb_rd1       (wb_rd1),
        .config_locked(config_locked)
    );

    always #2 clk = ~clk; // 4 ns period

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_value(
        input string       name,
        input logic [63:0] expected,
        input logic [63:0] actual
    );
        if (actual !== expected) begin
            err_cnt++;
            $display("FAIL time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
    endtask

    task automatic issue_entry(input stim_entry_t e);
        done_exp_t d;
        repeat (e.gap) drive_idle();
        @(posedge clk);
        #1;
        issue_valid = 1'b1;
        issue_op    = e.op;
        issue_id    = e.id;
        cfg_addr    = e.addr;
        cfg_data    = e.data;
        rs1         = e.rs1;
        rs2         = e.rs2;
        if (e.done_exp) begin
            d.is_use = (e.op == op_use);
            d.due    = d.is_use ? cyc + 2 : cyc + 1; // strobe sampled at the next edge
            d.id     = e.id;
            d.rd0    = e.rd0;
            d.rd1    = e.rd1;
            exp_q.push_back(d);
        end
    endtask

    task automatic check_cycle();
        logic      lock_exp;
        done_exp_t head;
        lock_exp = 1'b0;
        // a use holds the lock from its issue until its done cycle
        for (int i = 0; i < exp_q.size(); i++) begin
            if (exp_q[i].is_use && (exp_q[i].due == cyc || exp_q[i].due == cyc + 1)) begin
                lock_exp = 1'b1;
            end
        end
        check_value("config_locked", lock_exp, config_locked);
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            head = exp_q.pop_front();
            check_value("wb_done", 1, wb_done);
            check_value("wb_id", head.id, wb_id);
            check_value("wb_rd0", head.rd0, wb_rd0);
            check_value("wb_rd1", head.rd1, wb_rd1);
            held_id = head.id;
        end else begin
            check_value("wb_done", 0, wb_done);
            check_value("wb_id", held_id, wb_id); // last id held between completions
            check_value("wb_rd0", 0, wb_rd0); // data stays zero without done
            check_value("wb_rd1", 0, wb_rd1);
        end
    endtask

    always @(negedge clk) begin
        if (mon_en) begin
            check_cycle();
        end
    end

    initial begin
        int limit;
        @(posedge clk); // table is built at time zero
        limit = stim_q.size() * 8 + 100;
        repeat (limit) @(posedge clk);
        $display("TIMEOUT at %0t: the run did not finish within %0d clock cycles", $time, limit);
        $display("Test failures found");
        $fatal(1);
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue_op    = op_use;
        issue_id    = '0;
        cfg_addr    = '0;
        cfg_data    = '0;
        rs1         = '0;
        rs2         = '0;
        cyc         = 0;
        err_cnt     = 0;
        mon_en      = 1'b0;
        held_id     = '0;
        build_table();

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // state right after reset
        check_value("wb_done", 0, wb_done);
        check_value("config_locked", 0, config_locked);
        check_value("wb_id", 0, wb_id);
        check_value("wb_rd0", 0, wb_rd0);
        check_value("wb_rd1", 0, wb_rd1);
        mon_en = 1'b1;

        for (int i = 0; i < stim_q.size(); i++) begin
            issue_entry(stim_q[i]);
        end
        drive_idle();

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk); // no stray done afterwards

        if (err_cnt == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
